// ==== fetch.f ====
hdl/isa_pkg.sv
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/fetch_align.sv
hdl/predecode_lane.sv
hdl/fetch_queue.sv
hdl/instr_fetch.sv
tests/tb_instr_fetch.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_instr_fetch -f fetch.f -o sim_fetch
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_fetch)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" || exit 1
exit 0

// ==== tests/tb_instr_fetch.sv ====
`default_nettype none

module tb_instr_fetch;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	// outputs are looked at well after the falling edge, before the rising one
	localparam int SAMPLE_DLY = 40;
	localparam int MEM_WORDS = 256;
	localparam logic [31:0] SEED = 32'h5965_fd2e;

	logic clk = 1'b0;
	logic reset;
	logic redirect_valid;
	logic [31:0] redirect_pc;
	logic req_ready;
	logic resp_valid;
	logic [63:0] resp_data;
	logic out_ready;
	logic req_valid;
	logic [31:0] req_addr;
	logic out_valid;
	logic [31:0] out_pc;
	logic [31:0] out_instr;

	logic [31:0] mem [MEM_WORDS];
	logic random_ready;
	logic random_out;
	logic seen_resp;
	int pop_count;
	int slot0_jumps;
	int slot1_jumps;

	instr_fetch dut0 (
		.clk            (clk),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.req_ready      (req_ready),
		.resp_valid     (resp_valid),
		.resp_data      (resp_data),
		.out_ready      (out_ready),
		.req_valid      (req_valid),
		.req_addr       (req_addr),
		.out_valid      (out_valid),
		.out_pc         (out_pc),
		.out_instr      (out_instr)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopping after the first error");
	endtask

	function automatic logic is_jump(input logic [31:0] instr);
		return instr[31:26] == 6'h02 || instr[31:26] == 6'h03;
	endfunction

	// returns {pending jump, saved target, next pc} for the word at pc
	function automatic logic [64:0] next_expected(input logic [31:0] pc,
			input logic [32:0] state);
		logic [31:0] instr;
		logic [31:0] link;
		logic [31:0] target;
		instr = mem[pc[9:2]];
		link = pc + 32'd4;
		target = {link[31:28], instr[25:0], 2'b00};
		if (state[32])
			return {1'b0, 32'd0, state[31:0]};
		else if (is_jump(instr))
			return {1'b1, target, link};
		else
			return {1'b0, 32'd0, link};
	endfunction

	// about one word in eight is a jump, never one right after another
	task automatic fill_program();
		logic prev_jump;
		logic [31:0] w;
		logic [7:0] idx;
		prev_jump = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			idx = 8'(i);
			w = $urandom;
			if (i != MEM_WORDS - 1 && !prev_jump && $urandom_range(7) == 0) begin
				w = {($urandom_range(1) == 1) ? 6'h03 : 6'h02, 18'd0, 8'($urandom)};
				prev_jump = 1'b1;
			end else begin
				// J or JAL by chance becomes BLEZ or BGTZ
				if (is_jump(w))
					w[28] = 1'b1;
				prev_jump = 1'b0;
			end
			mem[idx] = w;
		end
	endtask

	task automatic wait_pops(input int target, input int limit);
		int cycles;
		cycles = 0;
		while (pop_count < target) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("timeout: fetch queue stopped delivering instructions");
				stop_run();
			end
		end
	endtask

	// memory model, one response exactly one cycle after acceptance
	initial begin : memory_model
		logic accepted;
		logic [31:0] acc_addr;
		accepted = 1'b0;
		acc_addr = '0;
		req_ready = 1'b0;
		resp_valid = 1'b0;
		resp_data = '0;
		forever begin
			@(negedge clk);
			resp_valid = accepted;
			if (accepted)
				resp_data = {mem[{acc_addr[9:3], 1'b1}], mem[{acc_addr[9:3], 1'b0}]};
			if (random_ready)
				req_ready = ($urandom_range(3) != 0);
			else
				req_ready = 1'b1;
			#SAMPLE_DLY;
			accepted = !reset && req_valid && req_ready;
			acc_addr = req_addr;
		end
	end

	initial begin : drive_ready
		out_ready = 1'b0;
		forever begin
			@(negedge clk);
			if (random_out)
				out_ready = ($urandom_range(1) == 1);
			else
				out_ready = 1'b1;
		end
	end

	initial begin : compare
		logic [31:0] exp_pc;
		logic [32:0] exp_state;
		logic [31:0] want_instr;
		exp_pc = '0;
		exp_state = '0;
		forever begin
			@(negedge clk);
			#SAMPLE_DLY;
			if (reset) begin
				assert (!req_valid && !out_valid) else begin
					$display("request or output active during reset");
					stop_run();
				end
			end else if (redirect_valid) begin
				assert (!out_valid) else begin
					$display("fetch queue presented data on a redirect clock");
					stop_run();
				end
				// stream restarts exactly at the redirect target
				exp_pc = redirect_pc;
				exp_state = '0;
			end else if (out_valid && out_ready) begin
				want_instr = mem[exp_pc[9:2]];
				assert (out_pc == exp_pc) else begin
					$display("Error out_pc: got %h, expected %h", out_pc, exp_pc);
					stop_run();
				end
				assert (out_instr == want_instr) else begin
					$display("Error out_instr: got %h, expected %h", out_instr, want_instr);
					stop_run();
				end
				if (!exp_state[32] && is_jump(want_instr)) begin
					if (exp_pc[2])
						slot1_jumps++;
					else
						slot0_jumps++;
				end
				{exp_state, exp_pc} = next_expected(exp_pc, exp_state);
				pop_count++;
			end
			if (!seen_resp) begin
				assert (!out_valid) else begin
					$display("output valid before any memory response");
					stop_run();
				end
			end
			if (resp_valid)
				seen_resp = 1'b1;
			if (req_valid) begin
				assert (req_addr[2:0] == 3'b000) else begin
					$display("Error req_addr: got %h, not packet aligned", req_addr);
					stop_run();
				end
			end
		end
	end

	initial begin : stimulus
		logic [7:0] idx;
		void'($urandom(SEED));
		reset = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		random_ready = 1'b0;
		random_out = 1'b0;
		seen_resp = 1'b0;
		pop_count = 0;
		slot0_jumps = 0;
		slot1_jumps = 0;
		fill_program();

		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		// plain fetch from 0, consumer always ready
		wait_pops(40, 2000);

		// random stalls on both sides
		random_ready = 1'b1;
		random_out = 1'b1;
		wait_pops(pop_count + 300, 6000);

		// redirects mid-stream, every other one into slot 1
		for (int r = 0; r < 8; r++) begin
			repeat ($urandom_range(20, 3)) @(negedge clk);
			idx = 8'($urandom);
			idx[0] = r[0];
			redirect_valid = 1'b1;
			redirect_pc = {22'd0, idx, 2'b00};
			@(negedge clk);
			redirect_valid = 1'b0;
			wait_pops(pop_count + 20, 1000);
		end

		if (slot0_jumps > 0 && slot1_jumps > 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("jumps were not followed from both slots, slot 0 %0d, slot 1 %0d",
				slot0_jumps, slot1_jumps);
			stop_run();
		end
	end

endmodule

`default_nettype wire

// ==== hdl/instr_fetch.sv ====
`default_nettype none

module instr_fetch import fetch_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               redirect_valid,
	input  logic [ADDR_W-1:0]  redirect_pc,
	input  logic               req_ready,
	input  logic               resp_valid,
	input  logic [PKT_W-1:0]   resp_data,
	input  logic               out_ready,
	output logic               req_valid,
	output logic [ADDR_W-1:0]  req_addr,
	output logic               out_valid,
	output logic [ADDR_W-1:0]  out_pc,
	output logic [INSTR_W-1:0] out_instr
);

	logic room;
	logic resp_use;
	logic delay_only;
	logic [ADDR_W-1:0] resp_pc;
	logic [FETCH_NUM-1:0] slot_valid;
	logic [FETCH_NUM-1:0] lane_delay;
	logic [FETCH_NUM-1:0] jump_hit;
	logic [FETCH_NUM-1:0] push_valid;
	logic [ADDR_W-1:0] slot_pc [FETCH_NUM];
	logic [ADDR_W-1:0] jump_target [FETCH_NUM];
	logic [ADDR_W-1:0] push_pc [FETCH_NUM];
	logic [INSTR_W-1:0] slot_instr [FETCH_NUM];
	logic [INSTR_W-1:0] push_instr [FETCH_NUM];

	pc_gen u_pc_gen (
		.clk            (clk),
		.reset          (reset),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.req_ready      (req_ready),
		.resp_valid     (resp_valid),
		.room           (room),
		.jump_hit       (jump_hit),
		.jump_target    (jump_target),
		.req_valid      (req_valid),
		.req_addr       (req_addr),
		.resp_pc        (resp_pc),
		.resp_use       (resp_use),
		.delay_only     (delay_only)
	);

	fetch_align u_align (
		.resp_use   (resp_use),
		.resp_pc    (resp_pc),
		.resp_data  (resp_data),
		.delay_only (delay_only),
		.slot_valid (slot_valid),
		.slot_pc    (slot_pc),
		.slot_instr (slot_instr)
	);

	for (genvar i = 0; i < FETCH_NUM; i++) begin : gen_lane
		// slot after a taken jump is its delay slot
		if (i == 0) begin : gen_first
			assign lane_delay[i] = delay_only;
		end else begin : gen_next
			assign lane_delay[i] = jump_hit[i-1];
		end

		// cf_kind left open, classification is for later stages
		predecode_lane u_lane (
			.slot_valid  (slot_valid[i]),
			.slot_pc     (slot_pc[i]),
			.slot_instr  (slot_instr[i]),
			.in_delay    (lane_delay[i]),
			.cf_kind     (),
			.jump_hit    (jump_hit[i]),
			.jump_target (jump_target[i]),
			.push_valid  (push_valid[i]),
			.push_pc     (push_pc[i]),
			.push_instr  (push_instr[i])
		);
	end

	fetch_queue u_queue (
		.clk        (clk),
		.reset      (reset),
		.flush      (redirect_valid),
		.push_valid (push_valid),
		.push_pc    (push_pc),
		.push_instr (push_instr),
		.out_ready  (out_ready),
		.room       (room),
		.out_valid  (out_valid),
		.out_pc     (out_pc),
		.out_instr  (out_instr)
	);

endmodule

`default_nettype wire

// ==== hdl/fetch_queue.sv ====
`default_nettype none

module fetch_queue import fetch_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 flush,
	input  logic [FETCH_NUM-1:0] push_valid,
	input  logic [ADDR_W-1:0]    push_pc [FETCH_NUM],
	input  logic [INSTR_W-1:0]   push_instr [FETCH_NUM],
	input  logic                 out_ready,
	output logic                 room,
	output logic                 out_valid,
	output logic [ADDR_W-1:0]    out_pc,
	output logic [INSTR_W-1:0]   out_instr
);

	logic [ADDR_W-1:0] pc_mem [QUEUE_DEPTH];
	logic [INSTR_W-1:0] instr_mem [QUEUE_DEPTH];
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] wr_addr [FETCH_NUM];
	logic [QCNT_W-1:0] count;
	logic [QCNT_W-1:0] push_num;
	logic pop;

	// valid lanes land in consecutive entries, gaps squeezed out
	always_comb begin
		push_num = '0;
		for (int i = 0; i < FETCH_NUM; i++) begin
			wr_addr[i] = wr_ptr + push_num[QPTR_W-1:0];
			if (push_valid[i])
				push_num = push_num + 1'b1;
		end
	end

	assign out_valid = (count != '0) && !flush;
	assign pop = out_valid && out_ready;
	assign out_pc = pc_mem[rd_ptr];
	assign out_instr = instr_mem[rd_ptr];

	// pops this cycle are not counted, so room is conservative
	assign room = (int'(count) + int'(push_num) + ROOM_MIN) <= QUEUE_DEPTH;

	always_ff @(posedge clk) begin
		if (!flush) begin
			for (int i = 0; i < FETCH_NUM; i++) begin
				if (push_valid[i]) begin
					pc_mem[wr_addr[i]] <= push_pc[i];
					instr_mem[wr_addr[i]] <= push_instr[i];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			wr_ptr <= wr_ptr + push_num[QPTR_W-1:0];
			rd_ptr <= rd_ptr + QPTR_W'(pop);
			count <= count + push_num - QCNT_W'(pop);
		end
	end

	// room gating in pc_gen must keep every packet inside the buffer
	a_no_overflow: assert property (@(posedge clk) disable iff (reset || flush)
		(int'(count) + int'(push_num)) <= QUEUE_DEPTH)
		else $error("fetch queue overflow");

	// an empty count must match the pointers, so no stale entry pops
	a_no_empty_pop: assert property (@(posedge clk) disable iff (reset)
		(count == '0) |-> (wr_ptr == rd_ptr))
		else $error("fetch queue pointers disagree with an empty count");

endmodule

`default_nettype wire

// ==== hdl/predecode_lane.sv ====
`default_nettype none

module predecode_lane import fetch_pkg::*, isa_pkg::*; (
	input  logic               slot_valid,
	input  logic [ADDR_W-1:0]  slot_pc,
	input  logic [INSTR_W-1:0] slot_instr,
	input  logic               in_delay,
	output cf_kind_e           cf_kind,
	output logic               jump_hit,
	output logic [ADDR_W-1:0]  jump_target,
	output logic               push_valid,
	output logic [ADDR_W-1:0]  push_pc,
	output logic [INSTR_W-1:0] push_instr
);

	opcode_e opcode;
	logic [OPC_W-1:0] funct;
	logic [ADDR_W-1:0] pc_plus4;

	assign opcode = to_opcode(slot_instr[OPC_LSB +: OPC_W]);
	assign funct = slot_instr[OPC_W-1:0];
	assign pc_plus4 = slot_pc + ADDR_W'(4);

	always_comb begin
		case (opcode)
			J: cf_kind = CF_JUMP;
			JAL: cf_kind = CF_CALL;
			// regimm covers bltz, bgez and the linking forms
			REGIMM, BEQ, BNE, BLEZ, BGTZ: cf_kind = CF_BRANCH;
			SPECIAL: begin
				if (funct == FUNCT_JR || funct == FUNCT_JALR)
					cf_kind = CF_JUMP_REG;
				else
					cf_kind = CF_NONE;
			end
			default: cf_kind = CF_NONE;
		endcase
	end

	// jump inside a delay slot is undefined, never followed
	assign jump_hit = slot_valid && !in_delay && (cf_kind == CF_JUMP || cf_kind == CF_CALL);
	// region of the delay slot, then the word index
	assign jump_target = {pc_plus4[ADDR_W-1:JIDX_W+2], slot_instr[JIDX_W-1:0], 2'b00};

	assign push_valid = slot_valid;
	assign push_pc = slot_pc;
	assign push_instr = slot_instr;

endmodule

`default_nettype wire

// ==== hdl/fetch_align.sv ====
`default_nettype none

module fetch_align import fetch_pkg::*; (
	input  logic                 resp_use,
	input  logic [ADDR_W-1:0]    resp_pc,
	input  logic [PKT_W-1:0]     resp_data,
	input  logic                 delay_only,
	output logic [FETCH_NUM-1:0] slot_valid,
	output logic [ADDR_W-1:0]    slot_pc [FETCH_NUM],
	output logic [INSTR_W-1:0]   slot_instr [FETCH_NUM]
);

	logic [ADDR_W-1:0] base_pc;
	// slot the fetch entered the packet at
	logic [PKT_OFF_W-3:0] first_slot;

	assign base_pc = {resp_pc[ADDR_W-1:PKT_OFF_W], {PKT_OFF_W{1'b0}}};
	assign first_slot = resp_pc[PKT_OFF_W-1:2];

	always_comb begin
		for (int i = 0; i < FETCH_NUM; i++) begin
			slot_pc[i] = base_pc + ADDR_W'(i * (INSTR_W / 8));
			// lower address word sits in the low bits
			slot_instr[i] = resp_data[i * INSTR_W +: INSTR_W];

			// words ahead of the entry point are not part of this stream
			slot_valid[i] = resp_use && (i >= int'(first_slot));

			// delay-only packet: keep the delay slot, drop what follows it
			if (delay_only && i != 0)
				slot_valid[i] = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pc_gen.sv ====
`default_nettype none

module pc_gen import fetch_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 redirect_valid,
	input  logic [ADDR_W-1:0]    redirect_pc,
	input  logic                 req_ready,
	input  logic                 resp_valid,
	input  logic                 room,
	input  logic [FETCH_NUM-1:0] jump_hit,
	input  logic [ADDR_W-1:0]    jump_target [FETCH_NUM],
	output logic                 req_valid,
	output logic [ADDR_W-1:0]    req_addr,
	output logic [ADDR_W-1:0]    resp_pc,
	output logic                 resp_use,
	output logic                 delay_only
);

	typedef enum logic {
		DS_NONE,
		DS_PENDING
	} ds_state_e;

	ds_state_e ds_state;
	logic fetch_en;
	logic outstanding;
	logic discard;
	logic req_fire;
	logic [ADDR_W-1:0] pc_q;
	logic [ADDR_W-1:0] pc_next;
	logic [ADDR_W-1:0] seq_pc;
	logic [ADDR_W-1:0] fetch_pc;
	logic [ADDR_W-1:0] req_pc;
	logic [ADDR_W-1:0] saved_target;

	assign resp_pc = req_pc;
	assign delay_only = (ds_state == DS_PENDING);
	assign resp_use = resp_valid && outstanding && !discard && !redirect_valid;

	assign seq_pc = {resp_pc[ADDR_W-1:PKT_OFF_W], {PKT_OFF_W{1'b0}}} + ADDR_W'(PKT_W / 8);

	// a jump in the last slot falls through to seq_pc for its delay slot
	always_comb begin
		if (jump_hit[0])
			pc_next = jump_target[0];
		else if (delay_only)
			pc_next = saved_target;
		else
			pc_next = seq_pc;
	end

	// next request follows the decode of the packet returning now
	assign fetch_pc = resp_use ? pc_next : pc_q;
	assign req_addr = {fetch_pc[ADDR_W-1:PKT_OFF_W], {PKT_OFF_W{1'b0}}};
	assign req_valid = fetch_en && room && !redirect_valid && (!outstanding || resp_valid);
	assign req_fire = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_en <= 1'b0;
			pc_q <= '0;
			outstanding <= 1'b0;
			discard <= 1'b0;
			ds_state <= DS_NONE;
		end else begin
			fetch_en <= 1'b1;
			if (redirect_valid) begin
				pc_q <= redirect_pc;
				ds_state <= DS_NONE;
				// a response still in flight belongs to the old stream
				outstanding <= outstanding && !resp_valid;
				discard <= outstanding && !resp_valid;
			end else begin
				if (resp_use)
					pc_q <= pc_next;
				if (req_fire)
					outstanding <= 1'b1;
				else if (resp_valid)
					outstanding <= 1'b0;
				if (resp_valid)
					discard <= 1'b0;
				if (resp_use)
					ds_state <= jump_hit[FETCH_NUM-1] ? DS_PENDING : DS_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire)
			req_pc <= fetch_pc;
		if (resp_use && jump_hit[FETCH_NUM-1])
			saved_target <= jump_target[FETCH_NUM-1];
	end

	a_req_stable: assert property (@(posedge clk) disable iff (reset || redirect_valid)
		req_valid && !req_ready |=> req_valid && $stable(req_addr))
		else $error("request dropped or changed while stalled");

	a_resp_expected: assert property (@(posedge clk) disable iff (reset)
		resp_valid |-> outstanding)
		else $error("response without an outstanding request");

endmodule

`default_nettype wire

// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	localparam int ADDR_W = 32;
	localparam int INSTR_W = 32;

	// slots per fetch packet
	localparam int FETCH_NUM = 2;
	localparam int PKT_W = FETCH_NUM * INSTR_W;
	// byte offset bits inside one packet
	localparam int PKT_OFF_W = $clog2(PKT_W / 8);

	localparam int QUEUE_DEPTH = 8;
	// free entries needed before a new request goes out
	localparam int ROOM_MIN = 4;
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	typedef enum logic [2:0] {
		CF_NONE,
		CF_BRANCH,
		CF_JUMP,
		CF_CALL,
		CF_JUMP_REG
	} cf_kind_e;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	// major opcode field
	localparam int OPC_LSB = 26;
	localparam int OPC_W = 6;

	// index field of J and JAL
	localparam int JIDX_W = 26;

	// funct codes of the register jumps under SPECIAL
	localparam logic [OPC_W-1:0] FUNCT_JR = 6'h08;
	localparam logic [OPC_W-1:0] FUNCT_JALR = 6'h09;

	typedef enum logic [OPC_W-1:0] {
		SPECIAL = 6'h00,
		REGIMM = 6'h01,
		J = 6'h02,
		JAL = 6'h03,
		BEQ = 6'h04,
		BNE = 6'h05,
		BLEZ = 6'h06,
		BGTZ = 6'h07,
		// anything the front end does not care about
		OTHER = 6'h3f
	} opcode_e;

	function automatic opcode_e to_opcode(input logic [OPC_W-1:0] raw);
		case (raw)
			SPECIAL, REGIMM, J, JAL, BEQ, BNE, BLEZ, BGTZ: return opcode_e'(raw);
			default: return OTHER;
		endcase
	endfunction

endpackage

`default_nettype wire
